//--- filelist.f
hw/isa_pkg.sv
hw/cmd_regs.sv
hw/instr_decoder.sv
hw/register_file.sv
hw/alu16.sv
hw/exec_sequencer.sv
hw/core_top.sv
test/core_checker.sv
test/core_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module core_tb -f filelist.f -o core_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/core_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -q '^=== PASS ===$'; then
    exit 0
fi
echo "Pass message not found"
exit 1

//--- test/core_tb.sv
`timescale 1ns/10ps

module core_tb;
    import isa_pkg::*;

    localparam int CLK_PERIOD = 100;
    localparam int NUM_TESTS  = 5;
    localparam int ACK_LIMIT  = 16;
    localparam int POLL_LIMIT = 16;

    logic                 clk;
    logic                 reset;
    logic                 wb_cyc;
    logic                 wb_stb;
    logic                 wb_we;
    logic [WB_ADDR_W-1:0] wb_adr;
    logic [WB_DATA_W-1:0] wb_dat_w;
    logic [WB_SEL_W-1:0]  wb_sel;
    logic                 wb_ack;
    logic [WB_DATA_W-1:0] wb_dat_r;

    // Expected register contents and the last value seen on source B
    logic [DATA_W-1:0] model_regs [NUM_REGS];
    logic [DATA_W-1:0] model_b;
    integer            seed;
    int                errors;
    int                checks;
    int                tests_failed;

    core_top u_dut (
        .clk      (clk),
        .reset    (reset),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_sel   (wb_sel),
        .wb_ack   (wb_ack),
        .wb_dat_r (wb_dat_r)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(NUM_TESTS * 2000 * CLK_PERIOD);
        $display("Watchdog expired, tests did not finish in %0d clock periods", NUM_TESTS * 2000);
        $display("=== FAIL ===");
        $finish;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        checks++;
        assert (got === expected)
        else begin
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, expected);
            errors++;
        end
    endtask

    task automatic wb_access(input logic we, input logic [2:0] adr, input logic [31:0] data,
                             input logic [3:0] sel, output logic [31:0] rdata);
        int n;
        @(negedge clk);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = data;
        wb_sel   = sel;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!wb_ack && n < ACK_LIMIT);
        rdata = wb_dat_r;
        assert (wb_ack)
        else begin
            $display("Wishbone access to address %0d was never acknowledged", adr);
            errors++;
        end
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_write(input logic [2:0] adr, input logic [31:0] data,
                            input logic [3:0] sel);
        logic [31:0] unused;
        wb_access(1'b1, adr, data, sel, unused);
    endtask

    task automatic wb_read(input logic [2:0] adr, output logic [31:0] data);
        wb_access(1'b0, adr, 32'h0, 4'h0, data);
    endtask

    function automatic logic [15:0] rand16();
        int r;
        r = $random(seed);
        return r[15:0];
    endfunction

    function automatic logic takes_b(input opcode_e op);
        return op == OP_READ_AB || op == OP_AND || op == OP_ADD || op == OP_SUB;
    endfunction

    function automatic logic [15:0] predict_alu(input opcode_e op, input logic [15:0] a,
                                                input logic [15:0] b, input logic [15:0] imm);
        case (op)
            OP_LOAD_IMM: return imm;
            OP_MOVE:     return a;
            OP_AND:      return a & b;
            OP_ADD:      return a + b;
            OP_SUB:      return a - b;
            OP_SHL:      return a << imm[3:0];
            default:     return 16'h0;
        endcase
    endfunction

    task automatic launch_instr(input logic [33:0] word);
        wb_write(ADDR_INSTR_LO, word[31:0], 4'hf);
        wb_write(ADDR_INSTR_HI, {30'h0, word[33:32]}, 4'h1);
    endtask

    task automatic wait_done(output logic [31:0] status);
        int n;
        n = 0;
        do begin
            wb_read(ADDR_STATUS, status);
            n++;
        end while (!status[STAT_DONE] && n < POLL_LIMIT);
        assert (status[STAT_DONE])
        else begin
            $display("Status never showed done after %0d polls", n);
            errors++;
        end
    endtask

    task automatic run_instr(input opcode_e op, input logic [4:0] rd, input logic [4:0] ra,
                             input logic [4:0] rb, input logic [15:0] imm);
        logic [33:0] word;
        logic [31:0] rdata;
        logic [15:0] exp_a;
        logic [15:0] exp_b;
        logic [15:0] exp_res;
        word    = {op, rd, ra, rb, imm};
        exp_a   = model_regs[ra];
        exp_b   = takes_b(op) ? model_regs[rb] : model_b;
        exp_res = predict_alu(op, exp_a, exp_b, imm);
        model_b = exp_b;
        if (op != OP_READ_A && op != OP_READ_AB)
            model_regs[rd] = exp_res;
        launch_instr(word);
        // First poll lands mid-sequence
        wb_read(ADDR_STATUS, rdata);
        check_value("status busy/done", {30'h0, rdata[1:0]}, 32'h1);
        wait_done(rdata);
        wb_read(ADDR_READ_DATA, rdata);
        check_value("read_data", rdata, {exp_b, exp_a});
        wb_read(ADDR_RESULT, rdata);
        check_value("result", rdata, {16'h0, exp_res});
    endtask

    task automatic finish_test(input string name, input int start_errors);
        if (errors == start_errors) begin
            $display("Test %s: ok", name);
        end else begin
            $display("Test %s: %0d errors", name, errors - start_errors);
            tests_failed++;
        end
    endtask

    task automatic reset_and_map_test();
        int start;
        logic [31:0] rdata;
        start = errors;
        for (int a = 0; a < 5; a++) begin
            wb_read(3'(a), rdata);
            check_value($sformatf("wb_dat_r at address %0d", a), rdata, 32'h0);
        end
        wb_write(ADDR_INSTR_LO, 32'h11223344, 4'hf);
        wb_write(ADDR_INSTR_LO, 32'haabbccdd, 4'b0101);
        wb_read(ADDR_INSTR_LO, rdata);
        check_value("instr_lo", rdata, 32'h11bb33dd);
        wb_write(ADDR_INSTR_LO, 32'h55667788, 4'b1010);
        wb_read(ADDR_INSTR_LO, rdata);
        check_value("instr_lo", rdata, 32'h55bb77dd);
        for (int i = 0; i < 16; i++)
            run_instr(OP_READ_AB, 5'd0, 5'(2 * i), 5'(2 * i + 1), 16'h0);
        finish_test("reset and register map", start);
    endtask

    task automatic load_read_test();
        int start;
        start = errors;
        for (int i = 0; i < NUM_REGS; i++)
            run_instr(OP_LOAD_IMM, 5'(i), 5'd0, 5'd0, rand16());
        for (int i = 0; i < NUM_REGS; i++)
            run_instr(OP_READ_A, 5'd0, 5'(i), 5'd0, 16'h0);
        for (int i = 0; i < NUM_REGS; i++)
            run_instr(OP_READ_AB, 5'd0, 5'(i), 5'(31 - i), 16'h0);
        finish_test("load and read", start);
    endtask

    task automatic add_sub_test();
        int start;
        start = errors;
        // Wrap-around corners
        run_instr(OP_LOAD_IMM, 5'd1, 5'd0, 5'd0, 16'hffff);
        run_instr(OP_LOAD_IMM, 5'd2, 5'd0, 5'd0, 16'h0001);
        run_instr(OP_LOAD_IMM, 5'd0, 5'd0, 5'd0, 16'h0000);
        run_instr(OP_ADD, 5'd3, 5'd1, 5'd2, 16'h0);
        run_instr(OP_SUB, 5'd4, 5'd0, 5'd2, 16'h0);
        run_instr(OP_READ_AB, 5'd0, 5'd3, 5'd4, 16'h0);
        for (int i = 0; i < 10; i++) begin
            run_instr(OP_LOAD_IMM, 5'd8, 5'd0, 5'd0, rand16());
            run_instr(OP_LOAD_IMM, 5'd9, 5'd0, 5'd0, rand16());
            run_instr(OP_ADD, 5'd10, 5'd8, 5'd9, rand16());
            run_instr(OP_SUB, 5'd11, 5'd9, 5'd8, rand16());
            run_instr(OP_READ_AB, 5'd0, 5'd10, 5'd11, 16'h0);
        end
        finish_test("add and subtract", start);
    endtask

    task automatic logic_shift_test();
        int start;
        logic [15:0] imm;
        start = errors;
        run_instr(OP_LOAD_IMM, 5'd12, 5'd0, 5'd0, rand16());
        run_instr(OP_LOAD_IMM, 5'd13, 5'd0, 5'd0, rand16());
        run_instr(OP_AND, 5'd12, 5'd12, 5'd13, 16'h0);
        run_instr(OP_MOVE, 5'd14, 5'd12, 5'd0, 16'h0);
        run_instr(OP_MOVE, 5'd13, 5'd13, 5'd0, 16'h0);
        run_instr(OP_READ_AB, 5'd0, 5'd12, 5'd14, 16'h0);
        for (int s = 0; s < 16; s++) begin
            // Upper immediate bits must not affect the shift
            imm = rand16();
            imm[3:0] = 4'(s);
            run_instr(OP_LOAD_IMM, 5'd15, 5'd0, 5'd0, rand16() | 16'h8001);
            run_instr(OP_SHL, 5'd15, 5'd15, 5'd0, imm);
            run_instr(OP_READ_A, 5'd0, 5'd15, 5'd0, 16'h0);
        end
        finish_test("and, move and shift", start);
    endtask

    task automatic overrun_test();
        int start;
        logic [31:0] status;
        logic [15:0] val;
        start = errors;
        val = rand16() | 16'h0001;
        model_regs[7] = val;
        launch_instr({OP_LOAD_IMM, 5'd7, 5'd7, 5'd7, val});
        // Would turn the word into SUB r7 = r7 - r7 if it were taken
        wb_write(ADDR_INSTR_HI, 32'h3, 4'h1);
        wait_done(status);
        check_value("status overrun", {31'h0, status[STAT_OVERRUN]}, 32'h1);
        wb_read(ADDR_RESULT, status);
        check_value("result", status, {16'h0, val});
        wb_write(ADDR_STATUS, 32'h4, 4'h1);
        wb_read(ADDR_STATUS, status);
        check_value("status", status, 32'h2);
        run_instr(OP_READ_A, 5'd0, 5'd7, 5'd0, 16'h0);
        finish_test("back-pressure", start);
    endtask

    initial begin
        seed         = 32'hb3c8;
        errors       = 0;
        checks       = 0;
        tests_failed = 0;
        model_b      = '0;
        for (int i = 0; i < NUM_REGS; i++)
            model_regs[i] = '0;
        reset    = 1'b1;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        wb_sel   = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        reset_and_map_test();
        load_read_test();
        add_sub_test();
        logic_shift_test();
        overrun_test();

        $display("Tests run %0d, tests failed %0d, checks %0d, errors %0d",
                 NUM_TESTS, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- test/core_checker.sv
`timescale 1ns/10ps

module core_checker (
    input logic                clk,
    input logic                reset,
    input logic                wb_ack,
    input logic                launch,
    input logic                busy,
    input logic                wr_en,
    input logic                done,
    input isa_pkg::seq_state_e state
);
    import isa_pkg::*;

    ack_single: assert property (@(posedge clk) disable iff (reset) wb_ack |=> !wb_ack)
        else $error("wb_ack stayed high for more than one cycle");

    // Done exactly three cycles after launch, both ways
    done_from_launch: assert property (@(posedge clk) disable iff (reset)
        $past(launch, 3) |-> done)
        else $error("done missing three cycles after launch");

    done_needs_launch: assert property (@(posedge clk) disable iff (reset)
        done |-> $past(launch, 3))
        else $error("done without a launch three cycles before");

    wr_in_write: assert property (@(posedge clk) disable iff (reset)
        wr_en |-> state == S_WRITE)
        else $error("wr_en outside S_WRITE");

    no_launch_busy: assert property (@(posedge clk) disable iff (reset) !(launch && busy))
        else $error("launch while busy");

endmodule

bind core_top core_checker u_checker (
    .clk    (clk),
    .reset  (reset),
    .wb_ack (wb_ack),
    .launch (launch),
    .busy   (busy),
    .wr_en  (wr_en),
    .done   (done),
    .state  (u_seq.state)
);

//--- hw/core_top.sv
`timescale 1ns/10ps

module core_top (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             wb_cyc,
    input  logic                             wb_stb,
    input  logic                             wb_we,
    input  logic [isa_pkg::WB_ADDR_W-1:0]    wb_adr,
    input  logic [isa_pkg::WB_DATA_W-1:0]    wb_dat_w,
    input  logic [isa_pkg::WB_SEL_W-1:0]     wb_sel,
    output logic                             wb_ack,
    output logic [isa_pkg::WB_DATA_W-1:0]    wb_dat_r
);
    import isa_pkg::*;

    logic                  launch;
    logic [INSTR_W-1:0]    instr;
    opcode_e               opcode;
    logic [REG_ADDR_W-1:0] wr_addr;
    logic [REG_ADDR_W-1:0] rd_addr_a;
    logic [REG_ADDR_W-1:0] rd_addr_b;
    logic [DATA_W-1:0]     imm;
    logic                  needs_b;
    logic                  writes_rd;
    logic                  busy;
    logic                  rd_en;
    logic                  rd_en_b;
    logic                  wr_en;
    logic                  done;
    logic [DATA_W-1:0]     rd_data_a;
    logic [DATA_W-1:0]     rd_data_b;
    logic [DATA_W-1:0]     alu_out;
    logic [DATA_W-1:0]     alu_result;

    cmd_regs u_cmd_regs (
        .clk        (clk),
        .reset      (reset),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_w   (wb_dat_w),
        .wb_sel     (wb_sel),
        .busy       (busy),
        .done       (done),
        .rd_data_a  (rd_data_a),
        .rd_data_b  (rd_data_b),
        .alu_result (alu_result),
        .wb_ack     (wb_ack),
        .wb_dat_r   (wb_dat_r),
        .launch     (launch),
        .instr      (instr)
    );

    instr_decoder u_decoder (
        .clk       (clk),
        .reset     (reset),
        .launch    (launch),
        .instr     (instr),
        .opcode    (opcode),
        .wr_addr   (wr_addr),
        .rd_addr_a (rd_addr_a),
        .rd_addr_b (rd_addr_b),
        .imm       (imm),
        .needs_b   (needs_b),
        .writes_rd (writes_rd)
    );

    exec_sequencer u_seq (
        .clk        (clk),
        .reset      (reset),
        .launch     (launch),
        .needs_b    (needs_b),
        .writes_rd  (writes_rd),
        .alu_out    (alu_out),
        .busy       (busy),
        .rd_en      (rd_en),
        .rd_en_b    (rd_en_b),
        .wr_en      (wr_en),
        .done       (done),
        .alu_result (alu_result)
    );

    // Registered ALU result doubles as write-back data
    register_file u_regfile (
        .clk       (clk),
        .reset     (reset),
        .rd_en     (rd_en),
        .rd_en_b   (rd_en_b),
        .rd_addr_a (rd_addr_a),
        .rd_addr_b (rd_addr_b),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (alu_result),
        .rd_data_a (rd_data_a),
        .rd_data_b (rd_data_b)
    );

    alu16 u_alu (
        .opcode (opcode),
        .a      (rd_data_a),
        .b      (rd_data_b),
        .imm    (imm),
        .result (alu_out)
    );

endmodule

//--- hw/exec_sequencer.sv
`timescale 1ns/10ps

module exec_sequencer (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             launch,
    input  logic                             needs_b,
    input  logic                             writes_rd,
    input  logic [isa_pkg::DATA_W-1:0]       alu_out,
    output logic                             busy,
    output logic                             rd_en,
    output logic                             rd_en_b,
    output logic                             wr_en,
    output logic                             done,
    output logic [isa_pkg::DATA_W-1:0]       alu_result
);
    import isa_pkg::*;

    seq_state_e state;
    seq_state_e state_next;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= S_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // Fixed walk, one cycle per step
    always_comb begin
        state_next = state;
        case (state)
            S_IDLE: begin
                if (launch)
                    state_next = S_READ;
            end
            S_READ:  state_next = S_EXEC;
            S_EXEC:  state_next = S_WRITE;
            S_WRITE: state_next = S_IDLE;
            default: state_next = S_IDLE;
        endcase
    end

    // Sources are valid in S_EXEC
    always_ff @(posedge clk) begin
        if (state == S_EXEC)
            alu_result <= alu_out;
    end

    assign busy    = (state != S_IDLE);
    assign rd_en   = (state == S_READ);
    assign rd_en_b = rd_en & needs_b;
    assign wr_en   = (state == S_WRITE) & writes_rd;
    assign done    = (state == S_WRITE);

endmodule

//--- hw/alu16.sv
`timescale 1ns/10ps

module alu16 (
    input  isa_pkg::opcode_e                 opcode,
    input  logic [isa_pkg::DATA_W-1:0]       a,
    input  logic [isa_pkg::DATA_W-1:0]       b,
    input  logic [isa_pkg::DATA_W-1:0]       imm,
    output logic [isa_pkg::DATA_W-1:0]       result
);
    import isa_pkg::*;

    always_comb begin
        case (opcode)
            OP_LOAD_IMM: result = imm;
            OP_MOVE:     result = a;
            OP_AND:      result = a & b;
            // Add and subtract wrap at 16 bits
            OP_ADD:      result = a + b;
            OP_SUB:      result = a - b;
            OP_SHL:      result = a << imm[3:0];
            default:     result = '0;
        endcase
    end

endmodule

//--- hw/register_file.sv
`timescale 1ns/10ps

module register_file (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             rd_en,
    input  logic                             rd_en_b,
    input  logic [isa_pkg::REG_ADDR_W-1:0]   rd_addr_a,
    input  logic [isa_pkg::REG_ADDR_W-1:0]   rd_addr_b,
    input  logic                             wr_en,
    input  logic [isa_pkg::REG_ADDR_W-1:0]   wr_addr,
    input  logic [isa_pkg::DATA_W-1:0]       wr_data,
    output logic [isa_pkg::DATA_W-1:0]       rd_data_a,
    output logic [isa_pkg::DATA_W-1:0]       rd_data_b
);
    import isa_pkg::*;

    logic [DATA_W-1:0] regs [NUM_REGS];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_REGS; i++)
                regs[i] <= '0;
        end else if (wr_en) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // Registered reads see the value from before a same-cycle write
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_data_a <= '0;
            rd_data_b <= '0;
        end else begin
            if (rd_en)
                rd_data_a <= regs[rd_addr_a];
            if (rd_en_b)
                rd_data_b <= regs[rd_addr_b];
        end
    end

endmodule

//--- hw/instr_decoder.sv
`timescale 1ns/10ps

module instr_decoder (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             launch,
    input  logic [isa_pkg::INSTR_W-1:0]      instr,
    output isa_pkg::opcode_e                 opcode,
    output logic [isa_pkg::REG_ADDR_W-1:0]   wr_addr,
    output logic [isa_pkg::REG_ADDR_W-1:0]   rd_addr_a,
    output logic [isa_pkg::REG_ADDR_W-1:0]   rd_addr_b,
    output logic [isa_pkg::DATA_W-1:0]       imm,
    output logic                             needs_b,
    output logic                             writes_rd
);
    import isa_pkg::*;

    logic [INSTR_W-1:0] instr_q;

    // Held for the whole sequence, host may stage the next words
    always_ff @(posedge clk) begin
        if (reset) begin
            instr_q <= '0;
        end else if (launch) begin
            instr_q <= instr;
        end
    end

    assign opcode    = opcode_e'(instr_q[OPC_LSB +: OPC_W]);
    assign wr_addr   = instr_q[RD_LSB +: REG_ADDR_W];
    assign rd_addr_a = instr_q[RSA_LSB +: REG_ADDR_W];
    assign rd_addr_b = instr_q[RSB_LSB +: REG_ADDR_W];
    assign imm       = instr_q[IMM_LSB +: DATA_W];

    always_comb begin
        needs_b   = 1'b0;
        writes_rd = 1'b1;
        case (opcode)
            OP_READ_A: begin
                writes_rd = 1'b0;
            end
            OP_READ_AB: begin
                needs_b   = 1'b1;
                writes_rd = 1'b0;
            end
            OP_AND, OP_ADD, OP_SUB: needs_b = 1'b1;
            default: ;
        endcase
    end

endmodule

//--- hw/cmd_regs.sv
`timescale 1ns/10ps

module cmd_regs (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             wb_cyc,
    input  logic                             wb_stb,
    input  logic                             wb_we,
    input  logic [isa_pkg::WB_ADDR_W-1:0]    wb_adr,
    input  logic [isa_pkg::WB_DATA_W-1:0]    wb_dat_w,
    input  logic [isa_pkg::WB_SEL_W-1:0]     wb_sel,
    input  logic                             busy,
    input  logic                             done,
    input  logic [isa_pkg::DATA_W-1:0]       rd_data_a,
    input  logic [isa_pkg::DATA_W-1:0]       rd_data_b,
    input  logic [isa_pkg::DATA_W-1:0]       alu_result,
    output logic                             wb_ack,
    output logic [isa_pkg::WB_DATA_W-1:0]    wb_dat_r,
    output logic                             launch,
    output logic [isa_pkg::INSTR_W-1:0]      instr
);
    import isa_pkg::*;

    logic [WB_DATA_W-1:0]  instr_lo;
    logic [INSTR_HI_W-1:0] instr_hi;
    logic                  done_flag;
    logic                  overrun_flag;
    logic [DATA_W-1:0]     src_a_q;
    logic [DATA_W-1:0]     src_b_q;
    logic [DATA_W-1:0]     result_q;
    logic                  req;
    logic                  wr_req;
    logic                  hi_write;
    logic                  ovr_clear;

    // New request only when no ack is pending, so ack lasts one cycle
    assign req       = wb_cyc & wb_stb & ~wb_ack;
    assign wr_req    = req & wb_we;
    assign hi_write  = wr_req && (wb_adr == ADDR_INSTR_HI);
    assign ovr_clear = wr_req && (wb_adr == ADDR_STATUS) && wb_sel[0]
                       && wb_dat_w[STAT_OVERRUN];

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= req;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            instr_lo <= '0;
            instr_hi <= '0;
        end else if (wr_req) begin
            if (wb_adr == ADDR_INSTR_LO) begin
                for (int i = 0; i < WB_SEL_W; i++) begin
                    if (wb_sel[i])
                        instr_lo[8*i +: 8] <= wb_dat_w[8*i +: 8];
                end
            end
            if (hi_write && wb_sel[0])
                instr_hi <= wb_dat_w[INSTR_HI_W-1:0];
        end
    end

    // Launch lands in the ack cycle; a busy core gets an overrun instead
    always_ff @(posedge clk) begin
        if (reset) begin
            launch       <= 1'b0;
            overrun_flag <= 1'b0;
            done_flag    <= 1'b0;
        end else begin
            launch <= hi_write && !busy;
            if (hi_write && busy)
                overrun_flag <= 1'b1;
            else if (ovr_clear)
                overrun_flag <= 1'b0;
            if (launch)
                done_flag <= 1'b0;
            else if (done)
                done_flag <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            src_a_q  <= '0;
            src_b_q  <= '0;
            result_q <= '0;
        end else if (done) begin
            src_a_q  <= rd_data_a;
            src_b_q  <= rd_data_b;
            result_q <= alu_result;
        end
    end

    always_comb begin
        wb_dat_r = '0;
        case (wb_adr)
            ADDR_INSTR_LO:  wb_dat_r = instr_lo;
            ADDR_INSTR_HI:  wb_dat_r[INSTR_HI_W-1:0] = instr_hi;
            ADDR_STATUS: begin
                wb_dat_r[STAT_BUSY]    = busy;
                wb_dat_r[STAT_DONE]    = done_flag;
                wb_dat_r[STAT_OVERRUN] = overrun_flag;
            end
            ADDR_READ_DATA: wb_dat_r = {src_b_q, src_a_q};
            ADDR_RESULT:    wb_dat_r[DATA_W-1:0] = result_q;
            default:        wb_dat_r = '0;
        endcase
    end

    assign instr = {instr_hi, instr_lo};

endmodule

//--- hw/isa_pkg.sv
package isa_pkg;

    localparam int DATA_W     = 16;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;
    localparam int INSTR_W    = 34;
    localparam int WB_DATA_W  = 32;
    localparam int WB_ADDR_W  = 3;
    localparam int WB_SEL_W   = WB_DATA_W / 8;
    localparam int INSTR_HI_W = INSTR_W - WB_DATA_W;
    localparam int OPC_W      = 3;

    // Low bit of each instruction field
    localparam int OPC_LSB = 31;
    localparam int RD_LSB  = 26;
    localparam int RSA_LSB = 21;
    localparam int RSB_LSB = 16;
    localparam int IMM_LSB = 0;

    localparam logic [WB_ADDR_W-1:0] ADDR_INSTR_LO  = 3'd0;
    localparam logic [WB_ADDR_W-1:0] ADDR_INSTR_HI  = 3'd1;
    localparam logic [WB_ADDR_W-1:0] ADDR_STATUS    = 3'd2;
    localparam logic [WB_ADDR_W-1:0] ADDR_READ_DATA = 3'd3;
    localparam logic [WB_ADDR_W-1:0] ADDR_RESULT    = 3'd4;

    // Status register bits
    localparam int STAT_BUSY    = 0;
    localparam int STAT_DONE    = 1;
    localparam int STAT_OVERRUN = 2;

    typedef enum logic [OPC_W-1:0] {
        OP_LOAD_IMM = 3'd0,
        OP_READ_A   = 3'd1,
        OP_READ_AB  = 3'd2,
        OP_MOVE     = 3'd3,
        OP_AND      = 3'd4,
        OP_ADD      = 3'd5,
        OP_SUB      = 3'd6,
        OP_SHL      = 3'd7
    } opcode_e;

    typedef enum logic [1:0] {
        S_IDLE,
        S_READ,
        S_EXEC,
        S_WRITE
    } seq_state_e;

endpackage
